// ==== Bender.yml ====
package:
  name: address_generation

sources:
  - files:
      - logic/agen_pkg.sv
      - logic/reg_view.sv
      - logic/mem_addr_gen.sv
      - logic/operand_select.sv
      - logic/uop_assemble.sv
      - logic/agen_pipe_reg.sv
      - logic/address_generation_top.sv
  - target: simulation
    files:
      - testbench/agen_checker.sv
      - testbench/agen_tb.sv

// ==== filelist.f ====
logic/agen_pkg.sv
logic/reg_view.sv
logic/mem_addr_gen.sv
logic/operand_select.sv
logic/uop_assemble.sv
logic/agen_pipe_reg.sv
logic/address_generation_top.sv
testbench/agen_checker.sv
testbench/agen_tb.sv

// ==== logic/address_generation_top.sv ====
/*
 * address generation stage
 * operand selection and address computation for one micro-op per handshake
 */
`timescale 1ns/10ps

module address_generation_top
    import agen_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       r_valid,
    output logic       r_ready,
    input  agen_req_t  r_req,
    input  uop_info_t  r_info,
    input  arch_regs_t r_regs,
    output logic       a_valid,
    input  logic       a_ready,
    output agen_uop_t  a_uop
);

    reg_slots_t        slots;
    operand_t          modrm_ea;
    logic [ADDR_W-1:0] op0_mem_addr;
    logic [ADDR_W-1:0] op1_mem_addr;
    operand_t          op0;
    operand_t          op1;
    agen_uop_t         uop;

    reg_view u_reg_view (
        .size  (r_req.size),
        .regs  (r_regs),
        .slots (slots)
    );

    mem_addr_gen u_mem_addr_gen (
        .req          (r_req),
        .regs         (r_regs),
        .modrm_ea     (modrm_ea),
        .op0_mem_addr (op0_mem_addr),
        .op1_mem_addr (op1_mem_addr)
    );

    // op0 string form is es:edi
    operand_select op0_sel (
        .kind     (r_req.op0_kind),
        .reg_idx  (r_req.op0_reg),
        .modrm    (r_req.modrm),
        .imm      (r_req.imm),
        .slots    (slots),
        .regs     (r_regs),
        .modrm_ea (modrm_ea),
        .mem_addr (op0_mem_addr),
        .operand  (op0)
    );

    // op1 string form is ds:esi or the override
    operand_select op1_sel (
        .kind     (r_req.op1_kind),
        .reg_idx  (r_req.op1_reg),
        .modrm    (r_req.modrm),
        .imm      (r_req.imm),
        .slots    (slots),
        .regs     (r_regs),
        .modrm_ea (modrm_ea),
        .mem_addr (op1_mem_addr),
        .operand  (op1)
    );

    uop_assemble u_uop_assemble (
        .req  (r_req),
        .info (r_info),
        .op0  (op0),
        .op1  (op1),
        .uop  (uop)
    );

    agen_pipe_reg u_pipe (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (r_valid),
        .in_ready  (r_ready),
        .in_uop    (uop),
        .out_valid (a_valid),
        .out_ready (a_ready),
        .out_uop   (a_uop)
    );

endmodule

// ==== logic/agen_pipe_reg.sv ====
/*
 * pipe register
 * one entry valid/ready stage holding the assembled micro-op, with flush
 */
`timescale 1ns/10ps

module agen_pipe_reg
    import agen_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  logic      in_valid,
    output logic      in_ready,
    input  agen_uop_t in_uop,
    output logic      out_valid,
    input  logic      out_ready,
    output agen_uop_t out_uop
);

    // take a new item when empty or when the held one leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // held item is dropped
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_uop <= in_uop;
        end
    end

endmodule

// ==== logic/agen_pkg.sv ====
/*
 * address generation stage package
 * shared widths, operand encodings, register snapshot and payload types
 */
package agen_pkg;

    localparam int ADDR_W    = 32;
    localparam int SEG_W     = 16;
    localparam int OPER_W    = 64;
    localparam int IMM_W     = 48;
    localparam int SEG_SHIFT = 4;
    localparam int NUM_GPR   = 8;
    localparam int NUM_SEG   = 6;

    localparam logic [1:0] MOD_REG      = 2'b11;
    // mod 00 with this rm means displacement only
    localparam logic [2:0] RM_DISP_ONLY = 3'd5;
    localparam logic [2:0] ESI_IDX      = 3'd6;
    localparam logic [2:0] EDI_IDX      = 3'd7;
    // stack_op bit that marks a pop
    localparam int STACK_POP_BIT        = 1;

    typedef enum logic [2:0] {
        kind_none  = 3'd0,
        kind_reg   = 3'd1,
        kind_seg   = 3'd2,
        kind_mmx   = 3'd3,
        kind_modrm = 3'd4,
        kind_imm   = 3'd5,
        kind_mem   = 3'd6,
        kind_sys   = 3'd7
    } operand_kind_e;

    typedef enum logic [2:0] {
        size_8   = 3'd1,
        size_16  = 3'd2,
        size_32  = 3'd3,
        size_mmx = 3'd5
    } op_size_e;

    typedef enum logic [2:0] {
        seg_es = 3'd0,
        seg_cs = 3'd1,
        seg_ss = 3'd2,
        seg_ds = 3'd3,
        seg_fs = 3'd4,
        seg_gs = 3'd5
    } seg_idx_e;

    // gpr slots 0..7 are eax, ecx, edx, ebx, esp, ebp, esi, edi
    typedef struct packed {
        logic [NUM_GPR-1:0][ADDR_W-1:0] gpr;
        logic [NUM_SEG-1:0][SEG_W-1:0]  seg;
        logic [NUM_GPR-1:0][OPER_W-1:0] mmx;
    } arch_regs_t;

    typedef logic [NUM_GPR-1:0][OPER_W-1:0] reg_slots_t;

    typedef struct packed {
        op_size_e          size;
        operand_kind_e     op0_kind;
        operand_kind_e     op1_kind;
        logic [2:0]        op0_reg;
        logic [2:0]        op1_reg;
        logic [7:0]        modrm;
        logic [7:0]        sib;
        logic [IMM_W-1:0]  imm;
        logic [ADDR_W-1:0] disp;
        seg_idx_e          seg_override;
        logic              seg_override_valid;
        logic [1:0]        stack_op;
        logic [ADDR_W-1:0] stack_address;
    } agen_req_t;

    typedef struct packed {
        logic              set_d_flag;
        logic              clear_d_flag;
        logic [3:0]        alu_op;
        logic [2:0]        flag_0;
        logic [2:0]        flag_1;
        logic [ADDR_W-1:0] pc;
        logic              branch_taken;
        logic [15:0]       opcode;
    } uop_info_t;

    typedef struct packed {
        logic [OPER_W-1:0] value;
        logic              is_address;
    } operand_t;

    typedef struct packed {
        operand_t          op0;
        operand_t          op1;
        logic [2:0]        op0_reg;
        logic [2:0]        op1_reg;
        logic              op0_is_reg;
        logic              op0_is_segment;
        logic              op0_is_mmx;
        logic              to_sys_controller;
        op_size_e          size;
        logic [IMM_W-1:0]  imm;
        logic [1:0]        stack_op;
        logic [ADDR_W-1:0] stack_address;
        uop_info_t         info;
    } agen_uop_t;

    // segment read by index, codes past gs read as zero
    function automatic logic [SEG_W-1:0] seg_lookup(input arch_regs_t regs,
                                                    input logic [2:0] idx);
        logic [SEG_W-1:0] seg;
        seg = '0;
        if (idx < 3'(NUM_SEG)) begin
            seg = regs.seg[idx];
        end
        return seg;
    endfunction

endpackage

// ==== logic/mem_addr_gen.sv ====
/*
 * memory address generator
 * computes the reduced modrm effective address (base plus displacement)
 * and the two string addresses es:edi and ds:esi
 */
`timescale 1ns/10ps

module mem_addr_gen
    import agen_pkg::*;
(
    input  agen_req_t          req,
    input  arch_regs_t         regs,
    output operand_t           modrm_ea,
    output logic [ADDR_W-1:0]  op0_mem_addr,
    output logic [ADDR_W-1:0]  op1_mem_addr
);

    logic [1:0]        mod_f;
    logic [2:0]        rm_f;
    logic [SEG_W-1:0]  src_seg;
    logic [ADDR_W-1:0] src_base;
    logic [ADDR_W-1:0] es_base;
    logic [ADDR_W-1:0] ea_offset;

    assign mod_f = req.modrm[7:6];
    assign rm_f  = req.modrm[2:0];

    // ds unless an override segment is given
    always_comb begin
        if (req.seg_override_valid) begin
            src_seg = seg_lookup(regs, req.seg_override);
        end else begin
            src_seg = regs.seg[seg_ds];
        end
    end

    assign src_base = ADDR_W'(src_seg) << SEG_SHIFT;
    // string destination is always es, never overridden
    assign es_base  = ADDR_W'(regs.seg[seg_es]) << SEG_SHIFT;

    assign op0_mem_addr = es_base + regs.gpr[EDI_IDX];
    assign op1_mem_addr = src_base + regs.gpr[ESI_IDX];

    // no sib byte, so rm 4 is plain esp
    always_comb begin
        case (mod_f)
            2'b00: begin
                if (rm_f == RM_DISP_ONLY) begin
                    ea_offset = req.disp;
                end else begin
                    ea_offset = regs.gpr[rm_f];
                end
            end
            default: begin
                ea_offset = regs.gpr[rm_f] + req.disp;
            end
        endcase
    end

    always_comb begin
        modrm_ea.value      = OPER_W'(src_base + ea_offset);
        // register direct form is not an address
        modrm_ea.is_address = (mod_f != MOD_REG);
    end

endmodule

// ==== logic/operand_select.sv ====
/*
 * operand select
 * picks one operand value from the register views, segments, mmx,
 * modrm result, immediate or string address according to its kind
 */
`timescale 1ns/10ps

module operand_select
    import agen_pkg::*;
(
    input  operand_kind_e     kind,
    input  logic [2:0]        reg_idx,
    input  logic [7:0]        modrm,
    input  logic [IMM_W-1:0]  imm,
    input  reg_slots_t        slots,
    input  arch_regs_t        regs,
    input  operand_t          modrm_ea,
    input  logic [ADDR_W-1:0] mem_addr,
    output operand_t          operand
);

    logic modrm_is_reg;

    assign modrm_is_reg = (modrm[7:6] == MOD_REG);

    always_comb begin
        operand = '0;
        case (kind)
            kind_reg: operand.value = slots[reg_idx];
            kind_seg: operand.value = OPER_W'(seg_lookup(regs, reg_idx));
            kind_mmx: operand.value = regs.mmx[reg_idx];
            kind_modrm: begin
                if (modrm_is_reg) begin
                    operand.value = slots[modrm[2:0]];
                end else begin
                    // memory form carries is_address from the ea
                    operand = modrm_ea;
                end
            end
            kind_imm: operand.value = OPER_W'(imm);
            kind_mem: begin
                operand.value      = OPER_W'(mem_addr);
                operand.is_address = 1'b1;
            end
            // none and sys carry no value
            default: operand = '0;
        endcase
    end

endmodule

// ==== logic/reg_view.sv ====
/*
 * register view
 * builds the eight size dependent register slots, zero extended to 64 bits
 */
`timescale 1ns/10ps

module reg_view
    import agen_pkg::*;
(
    input  op_size_e   size,
    input  arch_regs_t regs,
    output reg_slots_t slots
);

    always_comb begin
        slots = '0;
        for (int i = 0; i < NUM_GPR; i++) begin
            case (size)
                size_8: begin
                    // slots 4..7 map to ah, ch, dh, bh
                    slots[i] = OPER_W'(regs.gpr[i % 4][8 * (i / 4) +: 8]);
                end
                size_16: begin
                    slots[i] = OPER_W'(regs.gpr[i][15:0]);
                end
                size_32: begin
                    slots[i] = OPER_W'(regs.gpr[i]);
                end
                size_mmx: begin
                    slots[i] = regs.mmx[i];
                end
                default: begin
                    // unknown size codes give no view
                    slots[i] = '0;
                end
            endcase
        end
    end

endmodule

// ==== logic/uop_assemble.sv ====
/*
 * micro-op assembly
 * applies the pop override to op1, derives the destination flags and
 * packs the operands, request fields and sideband into the payload
 */
`timescale 1ns/10ps

module uop_assemble
    import agen_pkg::*;
(
    input  agen_req_t req,
    input  uop_info_t info,
    input  operand_t  op0,
    input  operand_t  op1,
    output agen_uop_t uop
);

    logic is_pop;
    logic modrm_is_reg;

    assign is_pop       = req.stack_op[STACK_POP_BIT];
    assign modrm_is_reg = (req.modrm[7:6] == MOD_REG);

    always_comb begin
        uop.op0 = op0;

        // pop reads from the stack, whatever op1 asked for
        if (is_pop) begin
            uop.op1.value      = OPER_W'(req.stack_address);
            uop.op1.is_address = 1'b1;
        end else begin
            uop.op1 = op1;
        end

        uop.op0_reg = req.op0_reg;
        uop.op1_reg = req.op1_reg;

        // destination kind flags
        uop.op0_is_reg        = (req.op0_kind == kind_reg) ||
                                ((req.op0_kind == kind_modrm) && modrm_is_reg);
        uop.op0_is_segment    = (req.op0_kind == kind_seg);
        uop.op0_is_mmx        = (req.size == size_mmx);
        uop.to_sys_controller = (req.op0_kind == kind_sys);

        uop.size          = req.size;
        uop.imm           = req.imm;
        uop.stack_op      = req.stack_op;
        uop.stack_address = req.stack_address;
        uop.info          = info;
    end

endmodule

// ==== testbench/agen_checker.sv ====
/*
 * handshake checker
 * concurrent assertions on the output side of the address generation stage
 */
`timescale 1ns/10ps

module agen_checker
    import agen_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      r_ready,
    input logic      a_valid,
    input logic      a_ready,
    input agen_uop_t a_uop
);

    int unsigned failures = 0;

    // pipe is empty once reset has been seen
    valid_after_reset: assert property (@(posedge clk) rst |=> !a_valid)
        else begin
            failures++;
            $error("a_valid high in the cycle after reset");
        end

    payload_held: assert property (@(posedge clk) disable iff (rst)
        (a_valid && !a_ready) |=> $stable(a_uop))
        else begin
            failures++;
            $error("a_uop changed while stalled");
        end

    ready_rule: assert property (@(posedge clk) disable iff (rst)
        r_ready == (!a_valid || a_ready))
        else begin
            failures++;
            $error("r_ready does not follow a_valid and a_ready");
        end

endmodule

bind address_generation_top agen_checker u_checker (.*);

// ==== testbench/agen_tb.sv ====
/*
 * address generation stage testbench
 * directed tests for operand kinds, modrm forms, string addresses,
 * pop override, sideband passthrough and pipe timing
 */
`timescale 1ns/10ps

module agen_tb
    import agen_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 5;
    localparam int HS_LIMIT     = 4;
    // transfers per test: views, modrm, string, pop/sys
    localparam int XFERS        = 5 * 8 * 2 + 4 * 8 + 9 + 4;
    localparam int RUN_CYCLES   = RESET_CYCLES + 2 * XFERS + 16;
    localparam int WATCHDOG_NS  = (RUN_CYCLES + 100) * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       flush = 1'b0;
    logic       r_valid = 1'b0;
    logic       r_ready;
    logic       a_valid;
    logic       a_ready = 1'b1;
    agen_req_t  req = '0;
    uop_info_t  info = '0;
    arch_regs_t regs = '0;
    agen_uop_t  a_uop;

    integer seed = 32'h4865920d;
    int     total_checks = 0;
    int     total_errors = 0;
    int     test_errors = 0;

    address_generation_top UUT (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r_req   (req),
        .r_info  (info),
        .r_regs  (regs),
        .a_valid (a_valid),
        .a_ready (a_ready),
        .a_uop   (a_uop)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // segment by index, nothing behind gs
    function automatic logic [SEG_W-1:0] seg16(input logic [2:0] idx);
        return (idx < 3'd6) ? regs.seg[idx] : 16'd0;
    endfunction

    function automatic logic [OPER_W-1:0] sized_view(input logic [2:0] idx);
        case (req.size)
            size_8: begin
                if (idx < 3'd4) begin
                    return {56'd0, regs.gpr[idx][7:0]};
                end
                // ah, ch, dh, bh
                return {56'd0, regs.gpr[idx[1:0]][15:8]};
            end
            size_16:  return {48'd0, regs.gpr[idx][15:0]};
            size_32:  return {32'd0, regs.gpr[idx]};
            size_mmx: return regs.mmx[idx];
            default:  return '0;
        endcase
    endfunction

    // real mode base of ds or the override segment
    function automatic logic [ADDR_W-1:0] data_base();
        logic [SEG_W-1:0] s;
        s = req.seg_override_valid ? seg16(req.seg_override) : regs.seg[3];
        return {12'd0, s, 4'h0};
    endfunction

    function automatic operand_t model_operand(input operand_kind_e kind,
                                               input logic [2:0] idx,
                                               input logic [ADDR_W-1:0] str_addr);
        operand_t    o;
        logic [2:0]  rm;
        logic [31:0] off;
        o  = '0;
        rm = req.modrm[2:0];
        case (kind)
            kind_reg: o.value = sized_view(idx);
            kind_seg: o.value = {48'd0, seg16(idx)};
            kind_mmx: o.value = regs.mmx[idx];
            kind_modrm: begin
                if (req.modrm[7:6] == 2'b11) begin
                    o.value = sized_view(rm);
                end else begin
                    if (req.modrm[7:6] == 2'b00) begin
                        off = (rm == 3'd5) ? req.disp : regs.gpr[rm];
                    end else begin
                        off = regs.gpr[rm] + req.disp;
                    end
                    o.value      = {32'd0, data_base() + off};
                    o.is_address = 1'b1;
                end
            end
            kind_imm: o.value = {16'd0, req.imm};
            kind_mem: begin
                o.value      = {32'd0, str_addr};
                o.is_address = 1'b1;
            end
            default: o = '0;
        endcase
        return o;
    endfunction

    function automatic agen_uop_t model_uop();
        agen_uop_t u;
        u     = '0;
        u.op0 = model_operand(req.op0_kind, req.op0_reg, {12'd0, regs.seg[0], 4'h0} + regs.gpr[7]);
        u.op1 = model_operand(req.op1_kind, req.op1_reg, data_base() + regs.gpr[6]);
        if (req.stack_op[1]) begin
            u.op1.value      = {32'd0, req.stack_address};
            u.op1.is_address = 1'b1;
        end
        u.op0_reg           = req.op0_reg;
        u.op1_reg           = req.op1_reg;
        u.op0_is_reg        = (req.op0_kind == kind_reg) ||
                              (req.op0_kind == kind_modrm && req.modrm[7:6] == 2'b11);
        u.op0_is_segment    = (req.op0_kind == kind_seg);
        u.op0_is_mmx        = (req.size == size_mmx);
        u.to_sys_controller = (req.op0_kind == kind_sys);
        u.size              = req.size;
        u.imm               = req.imm;
        u.stack_op          = req.stack_op;
        u.stack_address     = req.stack_address;
        u.info              = info;
        return u;
    endfunction

    task automatic expect_true(input logic cond, input string msg);
        total_checks++;
        assert (cond) else begin
            $display("[FAIL] %0t ns: %s", $time, msg);
            total_errors++;
            test_errors++;
        end
    endtask

    task automatic new_snapshot();
        logic [95:0] bits;
        for (int i = 0; i < $bits(arch_regs_t) / 32; i++) begin
            regs[i * 32 +: 32] = $random(seed);
        end
        bits = {$random(seed), $random(seed), $random(seed)};
        info = bits[$bits(uop_info_t)-1:0];
        req  = '0;
        req.modrm              = 8'($random(seed));
        req.sib                = 8'($random(seed));
        req.imm                = {16'($random(seed)), 32'($random(seed))};
        req.disp               = 32'($random(seed));
        req.stack_address      = 32'($random(seed));
        req.seg_override       = seg_idx_e'(3'($random(seed)));
        req.seg_override_valid = 1'($random(seed));
    endtask

    // present req, wait for acceptance, check the item one cycle later
    task automatic send_and_compare(input string what);
        agen_uop_t expected;
        int        waited;
        expected = model_uop();
        waited   = 0;
        r_valid  = 1'b1;
        while (!r_ready && waited < HS_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (!r_ready) begin
            $display("handshake timeout at %0t ns: r_ready stayed low for %s", $time, what);
            total_errors++;
            test_errors++;
        end else begin
            @(posedge clk);
            #DRIVE_DELAY;
            expect_true(a_valid === 1'b1, {what, ": a_valid low one cycle after accept"});
            expect_true(a_uop === expected,
                        $sformatf("%s: a_uop %h, expected %h", what, a_uop, expected));
        end
        r_valid = 1'b0;
    endtask

    task automatic finish_test(input string name);
        $display("test %-16s done, %0d mismatches", name, test_errors);
        test_errors = 0;
    endtask

    task automatic test_register_views();
        op_size_e sizes[5] = '{size_8, size_16, size_32, size_mmx, op_size_e'(3'd4)};
        for (int s = 0; s < 5; s++) begin
            for (int idx = 0; idx < 8; idx++) begin
                new_snapshot();
                req.size     = sizes[s];
                req.op0_kind = kind_reg;
                req.op0_reg  = 3'(idx);
                req.op1_kind = kind_seg;
                req.op1_reg  = 3'(idx);
                send_and_compare($sformatf("reg/seg size %0d idx %0d", sizes[s], idx));
                req.op0_kind = kind_mmx;
                req.op1_kind = kind_imm;
                send_and_compare($sformatf("mmx/imm size %0d idx %0d", sizes[s], idx));
            end
        end
        finish_test("register_views");
    endtask

    task automatic test_modrm_forms();
        for (int md = 0; md < 4; md++) begin
            for (int rm = 0; rm < 8; rm++) begin
                new_snapshot();
                req.size        = size_32;
                req.modrm[7:6]  = 2'(md);
                req.modrm[2:0]  = 3'(rm);
                req.op0_kind    = kind_modrm;
                req.op1_kind    = kind_reg;
                req.op1_reg     = 3'($random(seed));
                send_and_compare($sformatf("modrm mod %0d rm %0d", md, rm));
                if (md == 3) begin
                    expect_true(a_uop.op0_is_reg === 1'b1, "register form without op0_is_reg");
                end else begin
                    expect_true(a_uop.op0.is_address === 1'b1, "memory form without is_address");
                end
            end
        end
        finish_test("modrm_forms");
    endtask

    // s == 8 runs without an override
    task automatic test_string_addresses();
        for (int s = 0; s < 9; s++) begin
            new_snapshot();
            req.op0_kind           = kind_mem;
            req.op1_kind           = kind_mem;
            req.seg_override_valid = (s < 8);
            req.seg_override       = seg_idx_e'(3'(s));
            send_and_compare($sformatf("string override %0d", s));
        end
        finish_test("string_addresses");
    endtask

    task automatic test_pop_and_sys();
        for (int n = 0; n < 4; n++) begin
            new_snapshot();
            req.size     = size_16;
            req.stack_op = 2'(n);
            req.op0_kind = kind_sys;
            req.op1_kind = operand_kind_e'(3'($random(seed)));
            send_and_compare($sformatf("stack_op %0d", n));
            expect_true(a_uop.to_sys_controller === 1'b1, "kind_sys without to_sys_controller");
            expect_true(a_uop.info === info, "sideband fields changed");
        end
        finish_test("pop_and_sys");
    endtask

    task automatic test_backpressure_flush();
        agen_uop_t held;
        // let the last item leave so the stage starts empty
        r_valid = 1'b0;
        a_ready = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        new_snapshot();
        req.size     = size_32;
        req.op0_kind = kind_reg;
        req.op1_kind = kind_imm;
        held         = model_uop();
        a_ready      = 1'b0;
        r_valid      = 1'b1;
        expect_true(a_valid === 1'b0, "a_valid high while the stage is empty");
        expect_true(r_ready === 1'b1, "r_ready low while the stage is empty");
        @(posedge clk);
        #DRIVE_DELAY;
        // a second request waits behind the stalled one
        new_snapshot();
        for (int c = 0; c < 3; c++) begin
            expect_true(a_valid === 1'b1, "a_valid dropped under back-pressure");
            expect_true(a_uop === held, $sformatf("held a_uop %h, expected %h", a_uop, held));
            expect_true(r_ready === 1'b0, "r_ready high under back-pressure");
            @(posedge clk);
            #DRIVE_DELAY;
        end
        flush   = 1'b1;
        r_valid = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
        flush = 1'b0;
        expect_true(a_valid === 1'b0, "a_valid still high after flush");
        a_ready = 1'b1;
        finish_test("backpressure_flush");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t ns, the tests did not finish in time", $time);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int assert_fails;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        expect_true(a_valid === 1'b0 && r_ready === 1'b1, "wrong handshake state after reset");
        test_register_views();
        test_modrm_forms();
        test_string_addresses();
        test_pop_and_sys();
        test_backpressure_flush();
        assert_fails = UUT.u_checker.failures;
        $display("%0d checks, %0d mismatches, %0d assertion failures",
                 total_checks, total_errors, assert_fails);
        if (total_errors == 0 && assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
